// ==== files.f ====
rtl/dispatchPkg.sv
rtl/queueCount.sv
rtl/issueQueueTracker.sv
rtl/robAllocator.sv
rtl/dispatchStage.sv
verification/dispatchStage_props.sv
verification/dispatchStageTb.sv

// ==== verification/dispatchStageTb.sv ====
// ==========================================================
// testbench for the dispatch enqueue logic
// random fetch groups, issues and commits are checked every
// cycle against an occupancy model of the queue and ROB
// ==========================================================

`timescale 1ns/100ps

module dispatchStageTb import dispatchPkg::*; ();

	logic                             clk;
	logic                             rst;
	logic                             ce;
	logic                             branchMiss;
	fetchSlot [WAYS-1:0]              slots;
	logic                             issueValid;
	qId                               issueIdx;
	logic                             commitValid;
	qCount                            commitCnt;
	qCount                            queuedCnt;
	logic [WAYS-1:0]                  queuedOn;
	qCount                            renamedCnt;
	logic [$clog2(IQ_ENTRIES+1)-1:0]  occupancy;
	logic [$clog2(ROB_ENTRIES+1)-1:0] robCount;

	integer seed;

	// model of the issue queue and the ROB as they stand after the last edge
	logic [IQ_ENTRIES-1:0]  refIq;
	qId                     refIqTail;
	logic [ROB_ENTRIES-1:0] refRob;
	robId                   refRobHead;
	robId                   refRobTail;

	dispatchStage dispatchStage_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// the watchdog allows 2000 cycles after reset for a sequence of about 1500
	initial begin
		#((2000 + 10) * 8);
		$display("timeout: the test sequence did not end within 2000 cycles after reset");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	// a bound assertion failure ends the run at once
	always @(dispatchStage_inst.dispatchStageProps_inst.failCount) begin
		if (dispatchStage_inst.dispatchStageProps_inst.failCount != 0) begin
			$display("bound assertion failed at %0t ns", $time);
			$display("RESULT: FAIL");
			$fatal(1, "bound assertion failed");
		end
	end

	// ======================================================
	// model and stimulus
	// ======================================================

	function automatic logic chance(input int pct);
		return ({$random(seed)} % 100) < pct;
	endfunction

	// zero on a miss, an empty slot 0 or any busy tail entry, two when
	// slot 0 falls through to a valid slot 1, one otherwise
	function automatic qCount expectedCount();
		if (branchMiss || !slots[0].valid || refIq[refIqTail] || refIq[qId'(refIqTail + 1)] ||
			refRob[refRobTail] || refRob[robId'(refRobTail + 1)])
			return 2'd0;
		if (slots[1].valid && (slots[0].kind == kindPlain ||
			(slots[0].kind == kindBranch && !slots[0].predTaken)))
			return 2'd2;
		return 2'd1;
	endfunction

	task automatic updateModel(input qCount cnt);
		logic retireFirst;
		logic retireSecond;
		retireFirst = commitValid && (commitCnt != 2'd0) && refRob[refRobHead];
		retireSecond = retireFirst && (commitCnt == 2'd2) && refRob[robId'(refRobHead + 1)];
		if (issueValid)
			refIq[issueIdx] = 1'b0;
		if (retireFirst)
			refRob[refRobHead] = 1'b0;
		if (retireSecond)
			refRob[robId'(refRobHead + 1)] = 1'b0;
		refRobHead = refRobHead + robId'(retireFirst) + robId'(retireSecond);
		if (ce) begin
			for (int i = 0; i < cnt; i++) begin
				refIq[qId'(refIqTail + i)] = 1'b1;
				refRob[robId'(refRobTail + i)] = 1'b1;
			end
			refIqTail = refIqTail + qId'(cnt);
			refRobTail = refRobTail + robId'(cnt);
		end
	endtask

	// issue picks an occupied entry from a random start, commit only a live head
	task automatic driveInputs(input int missPct, input int issuePct, input int commitPct,
		input int cePct);
		logic [31:0] r;
		qId start;
		ce = chance(cePct);
		branchMiss = chance(missPct);
		for (int w = 0; w < WAYS; w++) begin
			r = $random(seed);
			slots[w].valid = r[7:0] < 8'd220;
			slots[w].kind = slotKind'(r[9:8]);
			slots[w].predTaken = r[10];
		end
		issueValid = 1'b0;
		issueIdx = '0;
		start = qId'($random(seed));
		for (int k = 0; k < IQ_ENTRIES; k++) begin
			if (!issueValid && refIq[qId'(start + k)]) begin
				issueValid = 1'b1;
				issueIdx = qId'(start + k);
			end
		end
		issueValid = issueValid && chance(issuePct);
		commitValid = chance(commitPct) && refRob[refRobHead];
		commitCnt = chance(50) ? 2'd2 : 2'd1;
	endtask

	task automatic reportMismatch(input string msg);
		$display("ERR %0t ns: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first mismatch");
	endtask

	// outputs are sampled mid-cycle and the model then steps to the next edge
	task automatic runCycles(input int cycles, input int missPct, input int issuePct,
		input int commitPct, input int cePct);
		qCount expCnt;
		repeat (cycles) begin
			@(posedge clk);
			#1;
			driveInputs(missPct, issuePct, commitPct, cePct);
			#3;
			expCnt = expectedCount();
			assert (queuedCnt == expCnt)
				else reportMismatch($sformatf("queuedCnt %0d, expected %0d", queuedCnt, expCnt));
			assert (occupancy == $countones(refIq))
				else reportMismatch($sformatf("occupancy %0d, expected %0d", occupancy,
					$countones(refIq)));
			assert (robCount == $countones(refRob))
				else reportMismatch($sformatf("robCount %0d, expected %0d", robCount,
					$countones(refRob)));
			updateModel(expCnt);
		end
	endtask

	// ======================================================
	// test sequence
	// ======================================================

	initial begin
		seed = 38198;
		rst = 1'b1;
		ce = 1'b0;
		branchMiss = 1'b0;
		slots = '0;
		issueValid = 1'b0;
		issueIdx = '0;
		commitValid = 1'b0;
		commitCnt = '0;
		refIq = '0;
		refIqTail = '0;
		refRob = '0;
		refRobHead = '0;
		refRobTail = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		#3;
		assert (queuedOn == '0 && renamedCnt == '0 && occupancy == '0 && robCount == '0)
			else reportMismatch("outputs not zero after reset");
		// misses only, then a queue that fills without issue
		runCycles(20, 100, 0, 0, 100);
		runCycles(60, 0, 0, 100, 100);
		// issues drain the queue while the ROB fills, then commits free it
		runCycles(80, 0, 100, 0, 100);
		runCycles(60, 0, 100, 100, 100);
		runCycles(20, 100, 0, 0, 100);
		runCycles(1260, 10, 60, 50, 80);
		// two more edges so the bound checks see the last decision
		repeat (2) @(posedge clk);
		if (dispatchStage_inst.dispatchStageProps_inst.failCount != 0) begin
			$display("%0d bound assertion failures",
				dispatchStage_inst.dispatchStageProps_inst.failCount);
			$display("RESULT: FAIL");
			$fatal(1, "bound assertions failed");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== verification/dispatchStage_props.sv ====
// ==========================================================
// concurrent checks on the registered outputs of the dispatch
// top, bound into every dispatchStage instance
// ==========================================================

`timescale 1ns/100ps

module dispatchStageProps import dispatchPkg::*; (
	input logic            clk,
	input logic            rst,
	input logic            ce,
	input qCount           queuedCnt,
	input logic [WAYS-1:0] queuedOn,
	input qCount           renamedCnt
);

	// failed assertions so far
	int failCount = 0;

	// reset clears both registered outputs by the following edge
	resetClears: assert property (@(posedge clk)
		rst |=> (queuedOn == '0 && renamedCnt == '0)) else begin
		$error("queuedOn or renamedCnt not cleared by reset");
		failCount++;
	end

	// queuedOn has one low bit set per slot counted the cycle before,
	// and stays empty when the stage was frozen
	onFollowsCount: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (queuedOn == ($past(ce) ? WAYS'((1 << $past(queuedCnt)) - 1) : '0)))
		else begin
		$error("queuedOn differs from the mask of the previous count");
		failCount++;
	end

	// with the stage frozen nothing is written
	ceFreezes: assert property (@(posedge clk) disable iff (rst)
		!ce |=> (queuedOn == '0)) else begin
		$error("queuedOn set after a cycle with ce low");
		failCount++;
	end

	// rename sees the count one cycle late, whatever ce was
	renamedFollows: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (renamedCnt == $past(queuedCnt))) else begin
		$error("renamedCnt differs from the previous queuedCnt");
		failCount++;
	end

endmodule

bind dispatchStage dispatchStageProps dispatchStageProps_inst (.*);

// ==== rtl/dispatchStage.sv ====
// ==========================================================
// top of the two-way dispatch enqueue logic
// the count block decides each cycle and both occupancy
// trackers follow its allocation mask on the next edge
// ==========================================================

`timescale 1ns/100ps

module dispatchStage import dispatchPkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             ce,
	input  logic                             branchMiss,
	input  fetchSlot [WAYS-1:0]              slots,
	input  logic                             issueValid,
	input  qId                               issueIdx,
	input  logic                             commitValid,
	input  qCount                            commitCnt,
	output qCount                            queuedCnt,
	output logic [WAYS-1:0]                  queuedOn,
	output qCount                            renamedCnt,
	output logic [$clog2(IQ_ENTRIES+1)-1:0]  occupancy,
	output logic [$clog2(ROB_ENTRIES+1)-1:0] robCount
);

	// tail positions and valid bits from the issue queue
	tailPair               tails;
	logic [IQ_ENTRIES-1:0] iqValid;

	// both ROB tail positions are free
	logic robTailFree;

	// allocation mask shared by both trackers
	logic [WAYS-1:0] alloc;

	// ======================================================
	// enqueue decision
	// ======================================================

	queueCount queueCount_inst (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.branchMiss  (branchMiss),
		.slots       (slots),
		.tails       (tails),
		.iqValid     (iqValid),
		.robTailFree (robTailFree),
		.queuedCnt   (queuedCnt),
		.alloc       (alloc),
		.queuedOn    (queuedOn),
		.renamedCnt  (renamedCnt)
	);

	// ======================================================
	// occupancy trackers
	// ======================================================

	issueQueueTracker issueQueueTracker_inst (
		.clk        (clk),
		.rst        (rst),
		.alloc      (alloc),
		.issueValid (issueValid),
		.issueIdx   (issueIdx),
		.tails      (tails),
		.iqValid    (iqValid),
		.occupancy  (occupancy)
	);

	// the ROB only reports whether its tail can take a full group
	robAllocator robAllocator_inst (
		.clk         (clk),
		.rst         (rst),
		.alloc       (alloc),
		.commitValid (commitValid),
		.commitCnt   (commitCnt),
		.robTailFree (robTailFree),
		.robCount    (robCount)
	);

endmodule

// ==== rtl/robAllocator.sv ====
// ==========================================================
// reorder buffer occupancy for the dispatch stage
// entries are allocated at the tail and retired in order from
// the head, one or two per commit strobe
// ==========================================================

`timescale 1ns/100ps

module robAllocator import dispatchPkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [WAYS-1:0]                  alloc,
	input  logic                             commitValid,
	input  qCount                            commitCnt,
	output logic                             robTailFree,
	output logic [$clog2(ROB_ENTRIES+1)-1:0] robCount
);

	// circular buffer state
	logic [ROB_ENTRIES-1:0] robValid;
	robId head;
	robId tail;

	// the entries right behind the head and the tail
	robId headNext;
	robId tailNext;

	// which of the two oldest entries retire this cycle
	logic commit0;
	logic commit1;

	// entries written this cycle
	qCount allocNum;

	// masks applied on the next edge
	logic [ROB_ENTRIES-1:0] setMask;
	logic [ROB_ENTRIES-1:0] clearMask;

	assign headNext = head + 1'b1;
	assign tailNext = tail + 1'b1;

	// the count block may place two slots, so it needs both positions
	assign robTailFree = !robValid[tail] && !robValid[tailNext];

	// ======================================================
	// in-order commit
	// ======================================================

	// retirement stops at the first entry that is not live, so the
	// head never walks past the tail
	assign commit0 = commitValid && (commitCnt != '0) && robValid[head];
	assign commit1 = commit0 && (commitCnt == qCount'(2)) && robValid[headNext];

	always_comb begin
		clearMask = '0;
		if (commit0)
			clearMask[head] = 1'b1;
		if (commit1)
			clearMask[headNext] = 1'b1;
	end

	// ======================================================
	// allocation
	// ======================================================

	// slot i of the group goes to the entry i places past the tail
	always_comb begin
		setMask  = '0;
		allocNum = '0;
		for (int i = 0; i < WAYS; i++) begin
			if (alloc[i]) begin
				setMask[robId'(tail + i)] = 1'b1;
				allocNum = allocNum + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			robValid <= '0;
			head     <= '0;
			tail     <= '0;
		end else begin
			robValid <= (robValid & ~clearMask) | setMask;
			head     <= head + robId'({commit1, commit0 ^ commit1});
			tail     <= tail + robId'(allocNum);
		end
	end

	// live entries, taken from the valid bits so a full buffer is not
	// confused with an empty one when head equals tail
	always_comb begin
		robCount = '0;
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			if (robValid[i])
				robCount = robCount + 1'b1;
		end
	end

endmodule

// ==== rtl/issueQueueTracker.sv ====
// ==========================================================
// occupancy tracker for the eight-entry issue queue
// entries are allocated at a wrapping tail from the alloc mask
// and freed out of order by single-cycle issue strobes
// ==========================================================

`timescale 1ns/100ps

module issueQueueTracker import dispatchPkg::*; (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [WAYS-1:0]                 alloc,
	input  logic                            issueValid,
	input  qId                              issueIdx,
	output tailPair                         tails,
	output logic [IQ_ENTRIES-1:0]           iqValid,
	output logic [$clog2(IQ_ENTRIES+1)-1:0] occupancy
);

	// position that the next slot 0 will occupy
	qId tail;

	// number of entries allocated this cycle
	qCount allocNum;

	// entries that allocation sets and that issue clears this cycle
	logic [IQ_ENTRIES-1:0] setMask;
	logic [IQ_ENTRIES-1:0] issueMask;

	// valid vector after this cycle's issue and allocation
	logic [IQ_ENTRIES-1:0] validNext;

	// ======================================================
	// tail positions
	// ======================================================

	// tail1 wraps with the index width, entry 7 is followed by entry 0
	always_comb begin
		tails.tail0 = tail;
		tails.tail1 = tail + 1'b1;
	end

	// ======================================================
	// next valid vector
	// ======================================================

	// slot 0 lands at tail0 and slot 1 right behind it at tail1
	always_comb begin
		setMask = '0;
		if (alloc[0])
			setMask[tails.tail0] = 1'b1;
		if (alloc[WAYS-1] && (WAYS > 1))
			setMask[tails.tail1] = 1'b1;
	end

	// one issue per cycle leaves the queue, from any position
	always_comb begin
		issueMask = '0;
		if (issueValid)
			issueMask[issueIdx] = 1'b1;
	end

	// allocation is applied after the clear, so it wins on a shared
	// entry, though the count block only allocates free entries and
	// the scheduler only issues occupied ones
	assign validNext = (iqValid & ~issueMask) | setMask;

	// the tail moves past every slot that was written
	always_comb begin
		allocNum = '0;
		for (int i = 0; i < WAYS; i++) begin
			if (alloc[i])
				allocNum = allocNum + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			iqValid <= '0;
			tail    <= '0;
		end else begin
			iqValid <= validNext;
			tail    <= tail + qId'(allocNum);
		end
	end

	// ======================================================
	// fill level
	// ======================================================

	// live entries for the scheduler, counted from the valid bits
	// because issue frees entries in any order
	always_comb begin
		occupancy = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (iqValid[i])
				occupancy = occupancy + 1'b1;
		end
	end

endmodule

// ==== rtl/queueCount.sv ====
// ==========================================================
// enqueue decision for the two-way dispatch stage
// it tells fetch in the same cycle how many slots enter the
// issue queue and ROB, and drives the allocation strobes
// ==========================================================

`timescale 1ns/100ps

module queueCount import dispatchPkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ce,
	input  logic                  branchMiss,
	input  fetchSlot [WAYS-1:0]   slots,
	input  tailPair               tails,
	input  logic [IQ_ENTRIES-1:0] iqValid,
	input  logic                  robTailFree,
	output qCount                 queuedCnt,
	output logic [WAYS-1:0]       alloc,
	output logic [WAYS-1:0]       queuedOn,
	output qCount                 renamedCnt
);

	// both issue queue tail entries are empty
	logic iqTailsFree;

	// nothing may enqueue this cycle
	logic blocked;

	// slot 0 does not redirect fetch, so the group may reach slot 1
	logic firstFallsThrough;

	// slot 1 joins slot 0 in the queue this cycle
	logic secondOk;

	// mask of slots that would enqueue if the stage were enabled
	logic [WAYS-1:0] queuedOnp;

	// ======================================================
	// enqueue rule
	// ======================================================

	// the tracker always offers two tail positions, so both must be
	// free before even the first slot may go in
	assign iqTailsFree = !iqValid[tails.tail0] && !iqValid[tails.tail1];

	// a miss flushes the group, and a full queue or ROB holds it back
	assign blocked = branchMiss || !slots[0].valid || !iqTailsFree || !robTailFree;

	// a break, a jump or a predicted taken branch ends the group
	// after slot 0, since the slot behind it is on the wrong path
	assign firstFallsThrough = (slots[0].kind == kindPlain) ||
		((slots[0].kind == kindBranch) && !slots[0].predTaken);

	// with a single way the last slot is slot 0 and the WAYS test
	// keeps the count at one
	assign secondOk = (WAYS > 1) && firstFallsThrough && slots[WAYS-1].valid;

	// the count and the mask always agree, slot 1 never enqueues alone
	always_comb begin
		queuedCnt = '0;
		queuedOnp = '0;
		if (!blocked) begin
			queuedCnt = qCount'(1);
			queuedOnp[0] = 1'b1;
			if (secondOk) begin
				queuedCnt = qCount'(2);
				queuedOnp[WAYS-1] = 1'b1;
			end
		end
	end

	// the stage enable is only looked at here, so the trackers see a
	// single allocation command and cannot disagree about it
	assign alloc = ce ? queuedOnp : '0;

	// ======================================================
	// registered outputs
	// ======================================================

	// queuedOn tells the next stage which slots were written on the
	// edge that closed the deciding cycle
	// renamedCnt is the count one cycle late for rename, and it keeps
	// running while ce is low
	always_ff @(posedge clk) begin
		if (rst) begin
			queuedOn   <= '0;
			renamedCnt <= '0;
		end else begin
			queuedOn   <= alloc;
			renamedCnt <= queuedCnt;
		end
	end

endmodule

// ==== rtl/dispatchPkg.sv ====
// ==========================================================
// shared sizes, index types and fetch slot attributes for the
// two-way dispatch stage
// every dispatch module imports this package with a wildcard
// ==========================================================

package dispatchPkg;

	// ======================================================
	// sizes
	// ======================================================

	// the fetch stage offers this many instruction slots per cycle
	localparam int WAYS = 2;

	// the issue queue holds eight entries and wraps on its tail
	localparam int IQ_ENTRIES = 8;

	// the reorder buffer is twice as deep as the issue queue
	localparam int ROB_ENTRIES = 16;

	// ======================================================
	// index and count types
	// ======================================================

	// an issue queue entry index
	typedef logic [$clog2(IQ_ENTRIES)-1:0] qId;

	// a reorder buffer entry index
	typedef logic [$clog2(ROB_ENTRIES)-1:0] robId;

	// how many slots enqueue in one cycle, from zero up to WAYS
	typedef logic [1:0] qCount;

	// ======================================================
	// fetch slot attributes
	// ======================================================

	// control class of a slot, which decides whether the group may
	// continue past it in the same cycle
	typedef enum logic [1:0] {
		kindPlain,
		kindBreak,
		kindJump,
		kindBranch
	} slotKind;

	// one slot as fetch presents it, without the instruction payload
	// predTaken only has meaning when kind is kindBranch
	typedef struct packed {
		logic    valid;
		slotKind kind;
		logic    predTaken;
	} fetchSlot;

	// the two issue queue positions that the next group would occupy
	typedef struct packed {
		qId tail0;
		qId tail1;
	} tailPair;

endpackage
